// File: Bender.yml
package:
  name: mshr

sources:
  - hdl/mem_bus_pkg.sv
  - hdl/mshr_pkg.sv
  - hdl/miss_pack.sv
  - hdl/mshr_queue.sv
  - hdl/mem_issue.sv
  - hdl/fill_retire.sv
  - hdl/mshr_top.sv
  - target: simulation
    files:
      - sim/mshr_checker.sv
      - sim/tb_top.sv

// File: hdl/fill_retire.sv
module fill_retire (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    fill_ack,
  input  logic                    wb_valid,
  input  mshr_pkg::entry_state_t  wb_state,
  input  mem_bus_pkg::addr_t      wb_addr,
  input  mem_bus_pkg::line_t      wb_data,
  input  mem_bus_pkg::bus_cmd_t   wb_cmd,
  output mshr_pkg::mshr_idx_t     retire_idx,
  output logic                    retire,
  output logic                    fill_valid,
  output mem_bus_pkg::addr_t      fill_addr,
  output mem_bus_pkg::line_t      fill_data
);
  import mem_bus_pkg::*;
  import mshr_pkg::*;

  logic wb_done;
  logic wb_is_load;

  assign wb_done    = wb_valid && (wb_state == done);
  assign wb_is_load = (wb_cmd == bus_load);

  // loads wait for the cache, stores leave straight away
  assign fill_valid = wb_done && wb_is_load;
  assign fill_addr  = wb_addr;
  assign fill_data  = wb_data;
  assign retire     = wb_done && (!wb_is_load || fill_ack);

  always_ff @(posedge clock) begin
    if (reset) begin
      retire_idx <= '0;
    end else if (retire) begin
      retire_idx <= retire_idx + 1'b1;
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    fill_ack |-> fill_valid)
    else $error("fill_ack without a fill on offer");

endmodule

// File: hdl/mem_bus_pkg.sv
package mem_bus_pkg;

  // processor-to-memory bus geometry
  localparam int addr_width = 32;
  localparam int line_width = 64;
  localparam int tag_width  = 4;

  // cache line address
  typedef logic [addr_width-1:0] addr_t;

  // one cache line of data
  typedef logic [line_width-1:0] line_t;

  // memory transaction tag, zero means no transaction
  typedef logic [tag_width-1:0] mem_tag_t;

  // bus command encoding
  typedef enum logic [1:0] {
    bus_none  = 2'd0,
    bus_load  = 2'd1,
    bus_store = 2'd2
  } bus_cmd_t;

endpackage

// File: hdl/mem_issue.sv
module mem_issue (
  input  logic                    clock,
  input  logic                    reset,
  input  mem_bus_pkg::mem_tag_t   mem_response,
  input  logic                    head_valid,
  input  mshr_pkg::entry_state_t  head_state,
  input  mem_bus_pkg::addr_t      head_addr,
  input  mem_bus_pkg::line_t      head_data,
  input  mem_bus_pkg::bus_cmd_t   head_cmd,
  output mshr_pkg::mshr_idx_t     issue_idx,
  output logic                    issue_accept,
  output mem_bus_pkg::mem_tag_t   issue_tag,
  output mem_bus_pkg::bus_cmd_t   mem_command,
  output mem_bus_pkg::addr_t      mem_addr,
  output mem_bus_pkg::line_t      mem_data
);
  import mem_bus_pkg::*;
  import mshr_pkg::*;

  logic head_active;

  // only a waiting entry goes out, the head stalls on an empty slot
  assign head_active = head_valid && (head_state == waiting);

  assign mem_command = head_active ? head_cmd : bus_none;
  assign mem_addr    = head_addr;
  assign mem_data    = head_data;

  // non-zero response accepts and names the transaction
  assign issue_accept = head_active && (mem_response != '0);
  assign issue_tag    = mem_response;

  always_ff @(posedge clock) begin
    if (reset) begin
      issue_idx <= '0;
    end else if (issue_accept) begin
      issue_idx <= issue_idx + 1'b1;
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    (mem_response != '0) |-> (mem_command != bus_none))
    else $error("memory accepted with no command on the bus");

endmodule

// File: hdl/miss_pack.sv
module miss_pack (
  input  logic                                              clock,
  input  logic                                              reset,
  input  logic [mshr_pkg::miss_ports-1:0]                   miss_valid,
  input  mem_bus_pkg::addr_t    [mshr_pkg::miss_ports-1:0]  miss_addr,
  input  mem_bus_pkg::line_t    [mshr_pkg::miss_ports-1:0]  miss_data,
  input  mem_bus_pkg::bus_cmd_t [mshr_pkg::miss_ports-1:0]  miss_cmd,
  output mshr_pkg::lane_count_t                             pack_count,
  output mem_bus_pkg::addr_t    [mshr_pkg::miss_ports-1:0]  lane_addr,
  output mem_bus_pkg::line_t    [mshr_pkg::miss_ports-1:0]  lane_data,
  output mem_bus_pkg::bus_cmd_t [mshr_pkg::miss_ports-1:0]  lane_cmd
);
  import mem_bus_pkg::*;
  import mshr_pkg::*;

  lane_count_t                   next_count;
  addr_t    [miss_ports-1:0]     next_addr;
  line_t    [miss_ports-1:0]     next_data;
  bus_cmd_t [miss_ports-1:0]     next_cmd;

  // priority chain: each valid input takes the next free output lane,
  // lowest input first
  always_comb begin
    next_count = '0;
    next_addr  = '0;
    next_data  = '0;
    for (int l = 0; l < miss_ports; l++) begin
      next_cmd[l] = bus_none;
    end
    for (int i = 0; i < miss_ports; i++) begin
      if (miss_valid[i]) begin
        next_addr[next_count] = miss_addr[i];
        next_data[next_count] = miss_data[i];
        next_cmd[next_count]  = miss_cmd[i];
        next_count            = next_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pack_count <= '0;
    end else begin
      pack_count <= next_count;
    end
  end

  // lane payload only matters below pack_count
  always_ff @(posedge clock) begin
    lane_addr <= next_addr;
    lane_data <= next_data;
    lane_cmd  <= next_cmd;
  end

endmodule

// File: hdl/mshr_pkg.sv
package mshr_pkg;

  // queue geometry
  localparam int mshr_depth = 8;
  localparam int miss_ports = 3;

  // entry index into the queue
  typedef logic [$clog2(mshr_depth)-1:0] mshr_idx_t;

  // number of misses packed in one cycle, 0 to 3
  typedef logic [1:0] lane_count_t;

  // per-entry progress
  typedef enum logic [1:0] {
    waiting     = 2'd0,
    in_progress = 2'd1,
    done        = 2'd2
  } entry_state_t;

endpackage

// File: hdl/mshr_queue.sv
module mshr_queue (
  input  logic                                              clock,
  input  logic                                              reset,
  input  mshr_pkg::lane_count_t                             pack_count,
  input  mem_bus_pkg::addr_t    [mshr_pkg::miss_ports-1:0]  lane_addr,
  input  mem_bus_pkg::line_t    [mshr_pkg::miss_ports-1:0]  lane_data,
  input  mem_bus_pkg::bus_cmd_t [mshr_pkg::miss_ports-1:0]  lane_cmd,
  input  mshr_pkg::mshr_idx_t                               issue_idx,
  input  logic                                              issue_accept,
  input  mem_bus_pkg::mem_tag_t                             issue_tag,
  input  mem_bus_pkg::mem_tag_t                             mem_tag,
  input  mem_bus_pkg::line_t                                mem_data_in,
  input  mshr_pkg::mshr_idx_t                               retire_idx,
  input  logic                                              retire,
  output logic                                              head_valid,
  output mshr_pkg::entry_state_t                            head_state,
  output mem_bus_pkg::addr_t                                head_addr,
  output mem_bus_pkg::line_t                                head_data,
  output mem_bus_pkg::bus_cmd_t                             head_cmd,
  output logic                                              wb_valid,
  output mshr_pkg::entry_state_t                            wb_state,
  output mem_bus_pkg::addr_t                                wb_addr,
  output mem_bus_pkg::line_t                                wb_data,
  output mem_bus_pkg::bus_cmd_t                             wb_cmd,
  output logic                                              mshr_ready,
  output logic                                              mshr_empty
);
  import mem_bus_pkg::*;
  import mshr_pkg::*;

  logic         [mshr_depth-1:0]          entry_valid;
  entry_state_t [mshr_depth-1:0]          entry_state;
  mem_tag_t                               entry_tag  [mshr_depth];
  addr_t                                  entry_addr [mshr_depth];
  line_t                                  entry_data [mshr_depth];
  bus_cmd_t                               entry_cmd  [mshr_depth];
  mshr_idx_t                              tail;
  mshr_idx_t                              lane_slot  [miss_ports];
  logic         [mshr_depth-1:0]          tag_hit;
  logic         [$clog2(mshr_depth+1)-1:0] free_count;

  always_comb begin
    for (int l = 0; l < miss_ports; l++) begin
      lane_slot[l] = tail + mshr_idx_t'(l);
    end
  end

  // load replies match on tag for entries already sent
  always_comb begin
    for (int i = 0; i < mshr_depth; i++) begin
      tag_hit[i] = entry_valid[i] && (entry_state[i] == in_progress) &&
                   (mem_tag != '0) && (entry_tag[i] == mem_tag);
    end
  end

  always_comb begin
    free_count = '0;
    for (int i = 0; i < mshr_depth; i++) begin
      if (!entry_valid[i]) begin
        free_count = free_count + 1'b1;
      end
    end
  end

  // leave room for the packed misses plus one more full strobe
  assign mshr_ready = free_count >= (pack_count + miss_ports);
  assign mshr_empty = ~|entry_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      entry_valid <= '0;
      for (int i = 0; i < mshr_depth; i++) begin
        entry_state[i] <= waiting;
      end
      tail <= '0;
    end else begin
      for (int i = 0; i < mshr_depth; i++) begin
        if (tag_hit[i]) begin
          entry_state[i] <= done;
        end
      end
      // a store needs no reply, so it is finished once accepted
      if (issue_accept) begin
        entry_state[issue_idx] <= (head_cmd == bus_store) ? done : in_progress;
      end
      if (retire) begin
        entry_valid[retire_idx] <= 1'b0;
      end
      for (int l = 0; l < miss_ports; l++) begin
        if (lane_count_t'(l) < pack_count) begin
          entry_valid[lane_slot[l]] <= 1'b1;
          entry_state[lane_slot[l]] <= waiting;
        end
      end
      tail <= tail + mshr_idx_t'(pack_count);
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < mshr_depth; i++) begin
      if (tag_hit[i]) begin
        entry_data[i] <= mem_data_in;
      end
    end
    if (issue_accept) begin
      entry_tag[issue_idx] <= issue_tag;
    end
    for (int l = 0; l < miss_ports; l++) begin
      if (lane_count_t'(l) < pack_count) begin
        entry_addr[lane_slot[l]] <= lane_addr[l];
        entry_data[lane_slot[l]] <= lane_data[l];
        entry_cmd[lane_slot[l]]  <= lane_cmd[l];
      end
    end
  end

  assign head_valid = entry_valid[issue_idx];
  assign head_state = entry_state[issue_idx];
  assign head_addr  = entry_addr[issue_idx];
  assign head_data  = entry_data[issue_idx];
  assign head_cmd   = entry_cmd[issue_idx];

  assign wb_valid = entry_valid[retire_idx];
  assign wb_state = entry_state[retire_idx];
  assign wb_addr  = entry_addr[retire_idx];
  assign wb_data  = entry_data[retire_idx];
  assign wb_cmd   = entry_cmd[retire_idx];

  // mshr_ready must have kept the tail clear of live entries
  for (genvar l = 0; l < miss_ports; l++) begin : g_alloc_chk
    assert property (@(posedge clock) disable iff (reset)
      (pack_count > lane_count_t'(l)) |-> !entry_valid[lane_slot[l]])
      else $error("miss allocated into a valid entry");
  end

endmodule

// File: hdl/mshr_top.sv
module mshr_top (
  input  logic                                              clock,
  input  logic                                              reset,
  input  logic [mshr_pkg::miss_ports-1:0]                   miss_valid,
  input  mem_bus_pkg::addr_t    [mshr_pkg::miss_ports-1:0]  miss_addr,
  input  mem_bus_pkg::line_t    [mshr_pkg::miss_ports-1:0]  miss_data,
  input  mem_bus_pkg::bus_cmd_t [mshr_pkg::miss_ports-1:0]  miss_cmd,
  output logic                                              mshr_ready,
  output logic                                              mshr_empty,
  output mem_bus_pkg::bus_cmd_t                             mem_command,
  output mem_bus_pkg::addr_t                                mem_addr,
  output mem_bus_pkg::line_t                                mem_data,
  input  mem_bus_pkg::mem_tag_t                             mem_response,
  input  mem_bus_pkg::mem_tag_t                             mem_tag,
  input  mem_bus_pkg::line_t                                mem_data_in,
  output logic                                              fill_valid,
  output mem_bus_pkg::addr_t                                fill_addr,
  output mem_bus_pkg::line_t                                fill_data,
  input  logic                                              fill_ack
);
  import mem_bus_pkg::*;
  import mshr_pkg::*;

  // packed misses
  lane_count_t              pack_count;
  addr_t    [miss_ports-1:0] lane_addr;
  line_t    [miss_ports-1:0] lane_data;
  bus_cmd_t [miss_ports-1:0] lane_cmd;

  // issue head
  mshr_idx_t    issue_idx;
  logic         issue_accept;
  mem_tag_t     issue_tag;
  logic         head_valid;
  entry_state_t head_state;
  addr_t        head_addr;
  line_t        head_data;
  bus_cmd_t     head_cmd;

  // writeback head
  mshr_idx_t    retire_idx;
  logic         retire;
  logic         wb_valid;
  entry_state_t wb_state;
  addr_t        wb_addr;
  line_t        wb_data;
  bus_cmd_t     wb_cmd;

  miss_pack u_miss_pack (
    .clock, .reset, .miss_valid, .miss_addr, .miss_data, .miss_cmd,
    .pack_count, .lane_addr, .lane_data, .lane_cmd
  );

  mshr_queue u_mshr_queue (
    .clock, .reset, .pack_count, .lane_addr, .lane_data, .lane_cmd,
    .issue_idx, .issue_accept, .issue_tag, .mem_tag, .mem_data_in,
    .retire_idx, .retire,
    .head_valid, .head_state, .head_addr, .head_data, .head_cmd,
    .wb_valid, .wb_state, .wb_addr, .wb_data, .wb_cmd,
    .mshr_ready, .mshr_empty
  );

  mem_issue u_mem_issue (
    .clock, .reset, .mem_response,
    .head_valid, .head_state, .head_addr, .head_data, .head_cmd,
    .issue_idx, .issue_accept, .issue_tag, .mem_command, .mem_addr, .mem_data
  );

  fill_retire u_fill_retire (
    .clock, .reset, .fill_ack,
    .wb_valid, .wb_state, .wb_addr, .wb_data, .wb_cmd,
    .retire_idx, .retire, .fill_valid, .fill_addr, .fill_data
  );

endmodule

// File: sim.f
hdl/mem_bus_pkg.sv
hdl/mshr_pkg.sv
hdl/miss_pack.sv
hdl/mshr_queue.sv
hdl/mem_issue.sv
hdl/fill_retire.sv
hdl/mshr_top.sv
sim/mshr_checker.sv
sim/tb_top.sv

// File: sim/mshr_checker.sv
module mshr_checker (
  input  logic                                              clock,
  input  logic                                              reset,
  input  logic [mshr_pkg::miss_ports-1:0]                   miss_valid,
  input  mem_bus_pkg::addr_t    [mshr_pkg::miss_ports-1:0]  miss_addr,
  input  mem_bus_pkg::line_t    [mshr_pkg::miss_ports-1:0]  miss_data,
  input  mem_bus_pkg::bus_cmd_t [mshr_pkg::miss_ports-1:0]  miss_cmd,
  input  logic                                              mshr_ready,
  input  logic                                              mshr_empty,
  input  mem_bus_pkg::bus_cmd_t                             mem_command,
  input  mem_bus_pkg::addr_t                                mem_addr,
  input  mem_bus_pkg::line_t                                mem_data,
  input  mem_bus_pkg::mem_tag_t                             mem_response,
  input  mem_bus_pkg::mem_tag_t                             mem_tag,
  input  mem_bus_pkg::line_t                                mem_data_in,
  input  logic                                              fill_valid,
  input  mem_bus_pkg::addr_t                                fill_addr,
  input  mem_bus_pkg::line_t                                fill_data,
  input  logic                                              fill_ack,
  input  logic                                              test_done,
  input  int                                                test_num,
  output logic                                              model_idle,
  output int                                                error_count,
  output int                                                check_count
);
  timeunit 1ns;
  timeprecision 100ps;
  import mem_bus_pkg::*;
  import mshr_pkg::*;

  // misses not yet accepted by memory in arrival order
  addr_t    iss_addr[$];
  line_t    iss_data[$];
  bus_cmd_t iss_cmd[$];
  int       iss_cycle[$];

  // accepted loads waiting for their fill
  addr_t    ld_addr[$];
  mem_tag_t ld_tag[$];
  logic     ld_back[$];
  line_t    ld_line[$];

  int   cycle;
  int   test_misses;
  int   errors_at_start;
  int   pending;
  logic found;

  initial begin
    model_idle      = 1'b1;
    error_count     = 0;
    check_count     = 0;
    cycle           = 0;
    test_misses     = 0;
    errors_at_start = 0;
  end

  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic report_fault(input string msg);
    $display("at %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic drop_oldest_load();
    ld_addr.delete(0);
    ld_tag.delete(0);
    ld_back.delete(0);
    ld_line.delete(0);
  endtask

  always @(posedge clock) begin
    if (reset) begin
      iss_addr.delete();
      iss_data.delete();
      iss_cmd.delete();
      iss_cycle.delete();
      ld_addr.delete();
      ld_tag.delete();
      ld_back.delete();
      ld_line.delete();
      cycle      = 0;
      model_idle = 1'b1;
    end else begin
      cycle++;
      // each of these misses holds an entry or a packed lane
      pending = iss_addr.size() + ld_addr.size();
      if (pending > mshr_depth - miss_ports) begin
        compare("mshr_ready", mshr_ready, 1'b0);
      end
      // fills leave in allocation order
      if (fill_valid && fill_ack) begin
        if (ld_addr.size() == 0) begin
          report_fault("a fill was delivered with no load outstanding");
        end else if (!ld_back[0]) begin
          report_fault("a fill was delivered before memory answered its load");
          drop_oldest_load();
        end else begin
          compare("fill_addr", fill_addr, ld_addr[0]);
          compare("fill_data", fill_data, ld_line[0]);
          drop_oldest_load();
        end
      end
      if (mem_tag != '0) begin
        found = 1'b0;
        for (int i = 0; i < ld_tag.size(); i++) begin
          if (!found && !ld_back[i] && ld_tag[i] == mem_tag) begin
            ld_back[i] = 1'b1;
            ld_line[i] = mem_data_in;
            found      = 1'b1;
          end
        end
        if (!found) begin
          report_fault($sformatf("memory answered tag %0d, which no load carries", mem_tag));
        end
      end
      if (mem_command != bus_none && mem_response != '0) begin
        if (iss_addr.size() == 0) begin
          report_fault("memory accepted a request with no miss pending");
        end else begin
          compare("mem_command", mem_command, iss_cmd[0]);
          compare("mem_addr", mem_addr, iss_addr[0]);
          compare("mem_data", mem_data, iss_data[0]);
          if (iss_cmd[0] == bus_load) begin
            ld_addr.push_back(iss_addr[0]);
            ld_tag.push_back(mem_response);
            ld_back.push_back(1'b0);
            ld_line.push_back('0);
          end
          iss_addr.delete(0);
          iss_data.delete(0);
          iss_cmd.delete(0);
          iss_cycle.delete(0);
        end
      end
      if (miss_valid != '0) begin
        // lowest valid lane is allocated first
        for (int i = 0; i < miss_ports; i++) begin
          if (miss_valid[i]) begin
            iss_addr.push_back(miss_addr[i]);
            iss_data.push_back(miss_data[i]);
            iss_cmd.push_back(miss_cmd[i]);
            iss_cycle.push_back(cycle);
            test_misses++;
          end
        end
      end
      // entries land two edges after the strobe
      if (mshr_empty && (ld_addr.size() != 0 ||
          (iss_addr.size() != 0 && iss_cycle[0] + 2 <= cycle))) begin
        report_fault("mshr_empty was high while misses were pending");
      end
      if (test_done) begin
        compare("mshr_empty", mshr_empty, 1'b1);
        compare("mshr_ready", mshr_ready, 1'b1);
        $display("test %0d: %0d misses, %0d errors", test_num, test_misses,
                 error_count - errors_at_start);
        test_misses     = 0;
        errors_at_start = error_count;
      end
      model_idle = (iss_addr.size() == 0) && (ld_addr.size() == 0);
    end
  end

endmodule

// File: sim/tb_top.sv
module tb_top;
  timeunit 1ns;
  timeprecision 100ps;
  import mem_bus_pkg::*;
  import mshr_pkg::*;

  logic                      clock = 1'b0;
  logic                      reset;
  logic [miss_ports-1:0]     miss_valid;
  addr_t    [miss_ports-1:0] miss_addr;
  line_t    [miss_ports-1:0] miss_data;
  bus_cmd_t [miss_ports-1:0] miss_cmd;
  logic                      mshr_ready;
  logic                      mshr_empty;
  bus_cmd_t                  mem_command;
  addr_t                     mem_addr;
  line_t                     mem_data;
  mem_tag_t                  mem_response;
  mem_tag_t                  mem_tag;
  line_t                     mem_data_in;
  logic                      fill_valid;
  addr_t                     fill_addr;
  line_t                     fill_data;
  logic                      fill_ack;

  logic test_done;
  int   test_num;
  logic model_idle;
  int   error_count;
  int   check_count;

  integer seed = 18800;
  int     misses_sent = 0;
  int     cycle_count = 0;
  int     tests_run = 0;

  // memory side state
  mem_tag_t    pend_tag[$];
  addr_t       pend_addr[$];
  logic [15:0] tag_busy;
  mem_tag_t    next_tag;
  mem_tag_t    freed_tag;
  int          k;

  mshr_top DUT (
    .clock, .reset, .miss_valid, .miss_addr, .miss_data, .miss_cmd,
    .mshr_ready, .mshr_empty, .mem_command, .mem_addr, .mem_data,
    .mem_response, .mem_tag, .mem_data_in,
    .fill_valid, .fill_addr, .fill_data, .fill_ack
  );

  mshr_checker u_checker (
    .clock, .reset, .miss_valid, .miss_addr, .miss_data, .miss_cmd,
    .mshr_ready, .mshr_empty, .mem_command, .mem_addr, .mem_data,
    .mem_response, .mem_tag, .mem_data_in,
    .fill_valid, .fill_addr, .fill_data, .fill_ack,
    .test_done, .test_num, .model_idle, .error_count, .check_count
  );

  initial begin
    forever #10 clock = ~clock;
  end

  function automatic int pick(input int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  // memory contents follow from the line address
  function automatic line_t reply_line(input addr_t addr);
    return {addr ^ 32'hc3a5_5a3c, ~addr + 32'd7};
  endfunction

  task automatic clear_misses();
    miss_valid = '0;
    miss_addr  = '0;
    miss_data  = '0;
    for (int i = 0; i < miss_ports; i++) begin
      miss_cmd[i] = bus_none;
    end
  endtask

  // lane_mode 0 one lane, 1 two or more, 2 any; cmd_mode 0 mixed, 1 loads, 2 stores
  task automatic run_test(input int num, input int strobes, input int lane_mode,
                          input int cmd_mode);
    int                    sent;
    logic [miss_ports-1:0] lanes;
    sent = 0;
    while (sent < strobes) begin
      @(negedge clock);
      clear_misses();
      if (mshr_ready && pick(4) != 0) begin
        case (lane_mode)
          0: lanes = 3'b001 << pick(3);
          1: lanes = 3'b111 ^ (3'b001 << pick(4));
          default: lanes = 3'(pick(7) + 1);
        endcase
        for (int i = 0; i < miss_ports; i++) begin
          if (lanes[i]) begin
            miss_addr[i] = $random(seed);
            miss_data[i] = {$random(seed), $random(seed)};
            case (cmd_mode)
              1: miss_cmd[i] = bus_load;
              2: miss_cmd[i] = bus_store;
              default: miss_cmd[i] = (pick(2) != 0) ? bus_store : bus_load;
            endcase
            misses_sent++;
          end
        end
        miss_valid = lanes;
        sent++;
      end
    end
    @(negedge clock);
    clear_misses();
    while (!model_idle) begin
      @(negedge clock);
    end
    // accepted stores still leave one entry per cycle
    for (int w = 0; w < mshr_depth && !mshr_empty; w++) begin
      @(negedge clock);
    end
    test_num  = num;
    test_done = 1'b1;
    @(negedge clock);
    test_done = 1'b0;
    tests_run++;
  endtask

  // memory and cache responders
  always @(negedge clock) begin
    if (reset !== 1'b0) begin
      mem_response = '0;
      mem_tag      = '0;
      mem_data_in  = '0;
      fill_ack     = 1'b0;
      tag_busy     = '0;
      next_tag     = '0;
      pend_tag.delete();
      pend_addr.delete();
    end else begin
      freed_tag   = '0;
      mem_tag     = '0;
      mem_data_in = '0;
      // any outstanding load may answer first
      if (pend_tag.size() > 0 && pick(3) == 0) begin
        k           = pick(pend_tag.size());
        mem_tag     = pend_tag[k];
        mem_data_in = reply_line(pend_addr[k]);
        freed_tag   = pend_tag[k];
        pend_tag.delete(k);
        pend_addr.delete(k);
      end
      mem_response = '0;
      if (mem_command != bus_none && pick(3) != 0) begin
        next_tag = (next_tag % 15) + 1;
        while (tag_busy[next_tag] || next_tag == freed_tag) begin
          next_tag = (next_tag % 15) + 1;
        end
        mem_response = next_tag;
        if (mem_command == bus_load) begin
          tag_busy[next_tag] = 1'b1;
          pend_tag.push_back(next_tag);
          pend_addr.push_back(mem_addr);
        end
      end
      if (freed_tag != '0) begin
        tag_busy[freed_tag] = 1'b0;
      end
      fill_ack = fill_valid && (pick(3) != 0);
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_count > 40 * misses_sent + 200) begin
      $display("timeout: the MSHR did not drain within %0d cycles", cycle_count);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    reset        = 1'b1;
    clear_misses();
    mem_response = '0;
    mem_tag      = '0;
    mem_data_in  = '0;
    fill_ack     = 1'b0;
    test_done    = 1'b0;
    test_num     = 0;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    run_test(1, 20, 0, 0);
    run_test(2, 20, 1, 0);
    run_test(3, 20, 2, 1);
    run_test(4, 15, 2, 2);
    run_test(5, 30, 2, 0);

    $display("%0d tests, %0d checks, %0d errors", tests_run, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
